/* hw/l3c_pkg.sv */
package l3c_pkg;

    // GLB word address and data word
    typedef logic [31:0] glb_addr_t;
    typedef logic [31:0] glb_data_t;

    // Words moved by one task
    typedef logic [15:0] pop_cnt_t;

    // Task handed to one lane by the layer controller
    typedef struct packed {
        glb_addr_t base_addr; // First GLB word of the task
        pop_cnt_t  pop_num;   // Words to fetch
    } lane_task_t;

    // Lane FIFO flags
    typedef struct packed {
        logic full;
        logic empty;
    } fifo_status_t;

    // Producer FSM
    typedef enum logic [1:0] {
        IDLE  = 2'd0, // Waiting for a task strobe
        FETCH = 2'd1, // Requesting GLB words
        DONE  = 2'd2  // One cycle done pulse
    } ifmap_state_e;

endpackage

/* hw/ifmap_fifo_ctrl.sv */
module ifmap_fifo_ctrl (
    input  logic                  clk,
    input  logic                  arst_n_i,

    // Controller side
    input  logic                  fifo_reset_i,    // Synchronous clear
    input  logic                  fifo_glb_busy_i, // Stalls every push
    input  logic                  need_pop_i,      // New task strobe
    input  l3c_pkg::lane_task_t   task_i,

    // Arbiter and GLB
    input  logic                  permit_push_i,
    input  l3c_pkg::glb_data_t    glb_read_data_i,

    // Lane FIFO
    input  l3c_pkg::fifo_status_t fifo_status_i,
    output logic                  push_o,
    output l3c_pkg::glb_data_t    push_data_o,

    // Arbiter request
    output logic                  read_req_o,
    output l3c_pkg::glb_addr_t    glb_read_addr_o,

    // Task done pulse
    output logic                  done_o
);

    l3c_pkg::ifmap_state_e state_q;
    l3c_pkg::ifmap_state_e state_d;
    l3c_pkg::glb_addr_t    addr_q;
    l3c_pkg::glb_addr_t    addr_d;
    l3c_pkg::pop_cnt_t     remain_q;
    l3c_pkg::pop_cnt_t     remain_d;
    logic                  push;
    logic                  last_push;

    // Request held for the whole fetch phase
    assign read_req_o = (state_q == l3c_pkg::FETCH);

    // Word is taken only when granted and there is room
    assign push = read_req_o & permit_push_i & ~fifo_status_i.full & ~fifo_glb_busy_i;
    assign last_push = push && (remain_q == l3c_pkg::pop_cnt_t'(1));

    assign push_o          = push;
    assign push_data_o     = glb_read_data_i; // Shared GLB bus forwarded as is
    assign glb_read_addr_o = addr_q;
    assign done_o          = (state_q == l3c_pkg::DONE);

    always_comb begin
        state_d  = state_q;
        addr_d   = addr_q;
        remain_d = remain_q;

        if (fifo_reset_i) begin
            state_d = l3c_pkg::IDLE; // Clear drops any task in flight
        end else begin
            case (state_q)
                l3c_pkg::IDLE: begin
                    if (need_pop_i) begin
                        addr_d   = task_i.base_addr;
                        remain_d = task_i.pop_num;
                        // Empty task goes straight to the done pulse
                        if (task_i.pop_num == '0) begin
                            state_d = l3c_pkg::DONE;
                        end else begin
                            state_d = l3c_pkg::FETCH;
                        end
                    end
                end

                l3c_pkg::FETCH: begin
                    if (push) begin
                        addr_d   = addr_q + l3c_pkg::glb_addr_t'(1);
                        remain_d = remain_q - l3c_pkg::pop_cnt_t'(1);
                        if (last_push) begin
                            state_d = l3c_pkg::DONE;
                        end
                    end
                end

                l3c_pkg::DONE: begin
                    state_d = l3c_pkg::IDLE;
                end

                default: begin
                    state_d = l3c_pkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q  <= l3c_pkg::IDLE;
            addr_q   <= '0;
            remain_q <= '0;
        end else begin
            state_q  <= state_d;
            addr_q   <= addr_d;
            remain_q <= remain_d;
        end
    end

endmodule

/* hw/lane_fifo.sv */
module lane_fifo #(
    parameter int FIFO_DEPTH = 4 // Power of two
)(
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  clear_i,     // Synchronous flush
    input  logic                  push_i,
    input  l3c_pkg::glb_data_t    push_data_i,
    input  logic                  pop_i,
    output l3c_pkg::glb_data_t    pop_data_o,  // Head word shown ahead
    output l3c_pkg::fifo_status_t status_o
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam logic [PTR_W:0] DEPTH_CNT = FIFO_DEPTH[PTR_W:0];

    l3c_pkg::glb_data_t mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             full;
    logic             empty;
    logic             do_push;
    logic             do_pop;

    assign full  = (count == DEPTH_CNT);
    assign empty = (count == '0);

    // Guards keep the pointers sane even on a stray request
    assign do_push = push_i & ~full;
    assign do_pop  = pop_i & ~empty;

    assign status_o.full  = full;
    assign status_o.empty = empty;
    assign pop_data_o     = mem[rd_ptr];

    // Storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (clear_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1; // Wraps at the power of two
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves occupancy unchanged
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* hw/pe_array_feeder.sv */
module pe_array_feeder #(
    parameter int NUM_LANES = 4
)(
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  clear_i,
    input  l3c_pkg::fifo_status_t lane_status_i [NUM_LANES],
    input  l3c_pkg::glb_data_t    lane_data_i   [NUM_LANES],
    input  logic                  pe_ready_i,
    output logic [NUM_LANES-1:0]  pop_o,      // Common pop to every lane
    output logic                  pe_valid_o,
    output l3c_pkg::glb_data_t    pe_data_o     [NUM_LANES]
);

    logic all_have_data;
    logic array_move;

    // Array moves only when every ifmap lane can give a word
    always_comb begin
        all_have_data = 1'b1;
        for (int n = 0; n < NUM_LANES; n++) begin
            if (lane_status_i[n].empty) begin
                all_have_data = 1'b0;
            end
        end
    end

    assign array_move = all_have_data & pe_ready_i & ~clear_i;
    assign pop_o      = {NUM_LANES{array_move}};

    // Row register toward the PE array
    always_ff @(posedge clk) begin
        if (array_move) begin
            for (int n = 0; n < NUM_LANES; n++) begin
                pe_data_o[n] <= lane_data_i[n];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pe_valid_o <= 1'b0;
        end else begin
            pe_valid_o <= array_move; // One cycle after the pop
        end
    end

endmodule

/* hw/l3c_fifo_ctrl.sv */
module l3c_fifo_ctrl #(
    parameter int NUM_LANES  = 4,
    parameter int FIFO_DEPTH = 4
)(
    input  logic                 clk,
    input  logic                 arst_n_i,

    // Layer controller
    input  logic                 fifo_reset_i,
    input  logic                 fifo_glb_busy_i,
    input  logic [NUM_LANES-1:0] need_pop_i,
    input  l3c_pkg::lane_task_t  task_i          [NUM_LANES],

    // Arbiter and GLB
    input  logic [NUM_LANES-1:0] permit_push_i,
    input  l3c_pkg::glb_data_t   glb_read_data_i, // One bus for all lanes
    output logic [NUM_LANES-1:0] read_req_o,
    output l3c_pkg::glb_addr_t   glb_read_addr_o [NUM_LANES],

    // Task done per lane
    output logic [NUM_LANES-1:0] done_o,

    // PE array
    input  logic                 pe_ready_i,
    output logic                 pe_valid_o,
    output l3c_pkg::glb_data_t   pe_data_o       [NUM_LANES]
);

    logic [NUM_LANES-1:0]  lane_push;
    logic [NUM_LANES-1:0]  lane_pop;
    l3c_pkg::glb_data_t    lane_push_data [NUM_LANES];
    l3c_pkg::glb_data_t    lane_head_data [NUM_LANES];
    l3c_pkg::fifo_status_t lane_status    [NUM_LANES];

    for (genvar i = 0; i < NUM_LANES; i++) begin : gen_lane
        ifmap_fifo_ctrl u_ifmap_fifo_ctrl (
            .clk             (clk),
            .arst_n_i        (arst_n_i),
            .fifo_reset_i    (fifo_reset_i),
            .fifo_glb_busy_i (fifo_glb_busy_i),
            .need_pop_i      (need_pop_i[i]),
            .task_i          (task_i[i]),
            .permit_push_i   (permit_push_i[i]),
            .fifo_status_i   (lane_status[i]),
            .glb_read_data_i (glb_read_data_i),
            .push_o          (lane_push[i]),
            .push_data_o     (lane_push_data[i]),
            .read_req_o      (read_req_o[i]),
            .glb_read_addr_o (glb_read_addr_o[i]),
            .done_o          (done_o[i])
        );

        lane_fifo #(
            .FIFO_DEPTH (FIFO_DEPTH)
        ) u_lane_fifo (
            .clk         (clk),
            .arst_n_i    (arst_n_i),
            .clear_i     (fifo_reset_i),
            .push_i      (lane_push[i]),
            .push_data_i (lane_push_data[i]),
            .pop_i       (lane_pop[i]),
            .pop_data_o  (lane_head_data[i]),
            .status_o    (lane_status[i])
        );
    end

    // Single consumer pops all lanes in lock-step
    pe_array_feeder #(
        .NUM_LANES (NUM_LANES)
    ) u_pe_array_feeder (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .clear_i       (fifo_reset_i),
        .lane_status_i (lane_status),
        .lane_data_i   (lane_head_data),
        .pe_ready_i    (pe_ready_i),
        .pop_o         (lane_pop),
        .pe_valid_o    (pe_valid_o),
        .pe_data_o     (pe_data_o)
    );

endmodule

/* bench/tb_clock_gen.sv */
module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 16
)(
    output logic clk_o,
    output logic arst_n_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        arst_n_o = 1'b1;
    end

endmodule

/* bench/l3c_fifo_ctrl_props.sv */
module l3c_fifo_ctrl_props #(
    parameter int NUM_LANES = 4
)(
    input logic                  clk,
    input logic                  arst_n_i,
    input logic [NUM_LANES-1:0]  push_i,
    input logic [NUM_LANES-1:0]  pop_i,
    input l3c_pkg::fifo_status_t status_i [NUM_LANES],
    input logic [NUM_LANES-1:0]  read_req_i,
    input logic [NUM_LANES-1:0]  done_i
);
    timeunit 1ns;
    timeprecision 100ps;

    logic any_empty;

    always_comb begin
        any_empty = 1'b0;
        for (int n = 0; n < NUM_LANES; n++) begin
            if (status_i[n].empty) begin
                any_empty = 1'b1;
            end
        end
    end

    for (genvar n = 0; n < NUM_LANES; n++) begin : gen_lane_chk
        a_push_not_full: assert property (@(posedge clk) disable iff (!arst_n_i)
            push_i[n] |-> !status_i[n].full)
            else $error("lane %0d pushed into a full FIFO", n);

        // Done lasts exactly one cycle
        a_done_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
            done_i[n] |=> !done_i[n])
            else $error("lane %0d held done_o for more than one cycle", n);
    end

    a_pop_all_ready: assert property (@(posedge clk) disable iff (!arst_n_i)
        (|pop_i) |-> !any_empty)
        else $error("feeder popped while a lane FIFO was empty");

    a_req_low_after_reset: assert property (@(posedge clk)
        $rose(arst_n_i) |-> (read_req_i == '0))
        else $error("read_req_o was high on leaving reset");

endmodule

bind l3c_fifo_ctrl l3c_fifo_ctrl_props #(
    .NUM_LANES (NUM_LANES)
) i_l3c_fifo_ctrl_props (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .push_i     (lane_push),
    .pop_i      (lane_pop),
    .status_i   (lane_status),
    .read_req_i (read_req_o),
    .done_i     (done_o)
);

/* bench/tb_l3c_fifo_ctrl.sv */
module tb_l3c_fifo_ctrl;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_LANES     = 4;
    localparam int FIFO_DEPTH    = 4;
    localparam int CLK_PERIOD_NS = 8;
    localparam int RESET_CYCLES  = 16;
    localparam int NUM_ROWS      = 7;
    localparam int RESET_AT      = 10; // Cycle of the mid-task clear
    localparam int QUIET_CYCLES  = 12;
    localparam int STALL_CYCLES  = 25; // Worst case per word per lane
    localparam int ROW_OVERHEAD  = 64;
    localparam int unsigned SEED = 32'hf610_a36b;
    localparam l3c_pkg::glb_data_t GLB_XOR = 32'h5a5a_0000;

    typedef struct packed {
        l3c_pkg::glb_addr_t [0:NUM_LANES-1] base;
        l3c_pkg::pop_cnt_t                  pop_num;
        int unsigned                        grant_pct;
        int unsigned                        busy_pct;
        int unsigned                        ready_pct;
        logic                               reset_mid;
    } test_row_t;

    localparam test_row_t TEST_TABLE [NUM_ROWS] = '{
        '{'{32'h0000_0100, 32'h0000_0200, 32'h0000_0300, 32'h0000_0400}, 16'd8, 100, 0, 100, 1'b0},
        '{'{32'h0000_1000, 32'h0000_2000, 32'h0000_3000, 32'h0000_4000}, 16'd20, 100, 0, 15, 1'b0},
        '{'{32'h0001_0ff0, 32'h0002_1ff8, 32'h0003_7ffe, 32'hffff_fffc}, 16'd16, 40, 30, 70, 1'b0},
        '{'{32'h0000_0a00, 32'h0000_0b00, 32'h0000_0c00, 32'h0000_0d00}, 16'd0, 100, 0, 100, 1'b0},
        '{'{32'h0000_5000, 32'h0000_5100, 32'h0000_5200, 32'h0000_5300}, 16'd12, 100, 0, 50, 1'b1},
        '{'{32'h0000_6000, 32'h0000_6100, 32'h0000_6200, 32'h0000_6300}, 16'd10, 80, 10, 80, 1'b0},
        '{'{32'h0000_7777, 32'h0000_8888, 32'h0000_9999, 32'h0000_aaaa}, 16'd6, 60, 20, 40, 1'b0}
    };

    logic                 clk;
    logic                 arst_n;
    logic                 fifo_reset;
    logic                 fifo_glb_busy;
    logic [NUM_LANES-1:0] need_pop;
    l3c_pkg::lane_task_t  task_arr      [NUM_LANES];
    logic [NUM_LANES-1:0] permit_push;
    l3c_pkg::glb_data_t   glb_read_data;
    logic                 pe_ready;
    logic [NUM_LANES-1:0] read_req;
    l3c_pkg::glb_addr_t   glb_read_addr [NUM_LANES];
    logic [NUM_LANES-1:0] done;
    logic                 pe_valid;
    l3c_pkg::glb_data_t   pe_data       [NUM_LANES];

    l3c_pkg::pop_cnt_t    rows_seen;
    l3c_pkg::pop_cnt_t    done_cnt      [NUM_LANES];
    int                   rr_ptr;

    tb_clock_gen #(
        .PERIOD_NS    (CLK_PERIOD_NS),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clock_gen (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    l3c_fifo_ctrl #(
        .NUM_LANES  (NUM_LANES),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_l3c_fifo_ctrl (
        .clk             (clk),
        .arst_n_i        (arst_n),
        .fifo_reset_i    (fifo_reset),
        .fifo_glb_busy_i (fifo_glb_busy),
        .need_pop_i      (need_pop),
        .task_i          (task_arr),
        .permit_push_i   (permit_push),
        .glb_read_data_i (glb_read_data),
        .read_req_o      (read_req),
        .glb_read_addr_o (glb_read_addr),
        .done_o          (done),
        .pe_ready_i      (pe_ready),
        .pe_valid_o      (pe_valid),
        .pe_data_o       (pe_data)
    );

    // GLB contents
    function automatic l3c_pkg::glb_data_t glb_word(input l3c_pkg::glb_addr_t addr);
        return addr ^ GLB_XOR;
    endfunction

    function automatic int watchdog_cycles();
        int total;
        total = RESET_CYCLES + ROW_OVERHEAD;
        for (int i = 0; i < NUM_ROWS; i++) begin
            total += int'(TEST_TABLE[i].pop_num) * NUM_LANES * STALL_CYCLES + ROW_OVERHEAD;
        end
        return total;
    endfunction

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Verification failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_data(input string name, input l3c_pkg::glb_data_t exp,
                              input l3c_pkg::glb_data_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("CHECK FAILED at %0t: %s expected %h actual %h",
                                    $time, name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_on_error($sformatf("CHECK FAILED at %0t: %s expected %b actual %b",
                                    $time, name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input l3c_pkg::pop_cnt_t exp,
                               input l3c_pkg::pop_cnt_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("CHECK FAILED at %0t: %s expected %0d actual %0d",
                                    $time, name, exp, act));
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1; // Drive and sample point
    endtask

    task automatic set_idle_inputs();
        need_pop      = '0;
        permit_push   = '0;
        glb_read_data = '0;
        fifo_glb_busy = 1'b0;
        pe_ready      = 1'b1;
    endtask

    task automatic expect_idle();
        check_flag("read_req_o (any lane)", 1'b0, |read_req);
        check_flag("done_o (any lane)", 1'b0, |done);
        check_flag("pe_valid_o", 1'b0, pe_valid);
    endtask

    // Arbiter grants one requesting lane round robin and the GLB answers on the shared bus
    task automatic drive_random(input test_row_t r);
        int   idx;
        logic granted;
        set_idle_inputs();
        granted = 1'b0;
        if ($urandom_range(99) < r.grant_pct) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                idx = (rr_ptr + i) % NUM_LANES;
                if (!granted && read_req[idx]) begin
                    permit_push[idx] = 1'b1;
                    glb_read_data    = glb_word(glb_read_addr[idx]);
                    rr_ptr           = (idx + 1) % NUM_LANES;
                    granted          = 1'b1;
                end
            end
        end
        fifo_glb_busy = ($urandom_range(99) < r.busy_pct);
        pe_ready      = ($urandom_range(99) < r.ready_pct);
    endtask

    task automatic sample_row(input test_row_t r, input int cyc);
        for (int n = 0; n < NUM_LANES; n++) begin
            if (done[n]) begin
                done_cnt[n] = done_cnt[n] + l3c_pkg::pop_cnt_t'(1);
            end
            if (cyc == 0) begin
                check_flag($sformatf("read_req_o[%0d]", n), r.pop_num != '0, read_req[n]);
            end
            if (r.pop_num == '0) begin
                check_flag($sformatf("read_req_o[%0d]", n), 1'b0, read_req[n]);
                if (cyc == 0) begin
                    check_flag($sformatf("done_o[%0d]", n), 1'b1, done[n]);
                end
            end
        end
        if (pe_valid) begin
            if (rows_seen == r.pop_num) begin
                stop_on_error("pe_valid_o rose after every row of the task was seen");
            end
            for (int n = 0; n < NUM_LANES; n++) begin
                check_data($sformatf("pe_data_o[%0d] row %0d", n, rows_seen),
                           glb_word(r.base[n] + l3c_pkg::glb_addr_t'(rows_seen)), pe_data[n]);
            end
            rows_seen = rows_seen + l3c_pkg::pop_cnt_t'(1);
        end
    endtask

    task automatic run_row(input int idx, input test_row_t r);
        int   cyc;
        logic all_done;
        $display("Row %0d: pop_num %0d grant %0d busy %0d ready %0d clear %b",
                 idx, r.pop_num, r.grant_pct, r.busy_pct, r.ready_pct, r.reset_mid);
        rows_seen = '0;
        for (int n = 0; n < NUM_LANES; n++) begin
            done_cnt[n] = '0;
        end
        next_cycle();
        for (int n = 0; n < NUM_LANES; n++) begin
            task_arr[n] = '{base_addr: r.base[n], pop_num: r.pop_num};
        end
        need_pop = '1;
        cyc = 0;
        forever begin
            next_cycle();
            sample_row(r, cyc);
            all_done = 1'b1;
            for (int n = 0; n < NUM_LANES; n++) begin
                if (done_cnt[n] == '0) begin
                    all_done = 1'b0;
                end
            end
            if (all_done) begin
                break;
            end
            if (r.reset_mid && cyc == RESET_AT) begin
                break;
            end
            drive_random(r);
            cyc++;
        end
        set_idle_inputs();
        if (r.reset_mid) begin
            fifo_reset = 1'b1;
            next_cycle();
            fifo_reset = 1'b0;
            expect_idle();
        end
        // Words still queued drain as rows, nothing else may follow the task
        repeat (QUIET_CYCLES) begin
            next_cycle();
            cyc++;
            if (r.reset_mid) begin
                expect_idle();
            end else begin
                check_flag("read_req_o (any lane)", 1'b0, |read_req);
                sample_row(r, cyc);
            end
        end
        if (!r.reset_mid) begin
            check_count("valid rows", r.pop_num, rows_seen);
            for (int n = 0; n < NUM_LANES; n++) begin
                check_count($sformatf("done_o[%0d] pulses", n), 16'd1, done_cnt[n]);
            end
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rr_ptr        = 0;
        fifo_reset    = 1'b0;
        need_pop      = '0;
        permit_push   = '0;
        glb_read_data = '0;
        fifo_glb_busy = 1'b0;
        pe_ready      = 1'b0;
        for (int n = 0; n < NUM_LANES; n++) begin
            task_arr[n] = '0;
        end

        // Outputs quiet during reset and on release
        do begin
            next_cycle();
            expect_idle();
        end while (!arst_n);

        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i, TEST_TABLE[i]);
        end

        $display("Verification passed");
        $finish;
    end

    initial begin
        #(watchdog_cycles() * CLK_PERIOD_NS);
        stop_on_error($sformatf("Watchdog timeout: the run did not finish within %0d cycles",
                                watchdog_cycles()));
    end

endmodule

/* sim.f */
hw/l3c_pkg.sv
hw/ifmap_fifo_ctrl.sv
hw/lane_fifo.sv
hw/pe_array_feeder.sv
hw/l3c_fifo_ctrl.sv
bench/tb_clock_gen.sv
bench/l3c_fifo_ctrl_props.sv
bench/tb_l3c_fifo_ctrl.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then decide from the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_l3c_fifo_ctrl \
    -f sim.f \
    -o sim_tb \
    && ./obj_dir/sim_tb 2>&1 | tee sim.log

grep -q "^Verification passed$" sim.log 2>/dev/null \
    && echo "Simulation PASS" \
    && exit 0 \
    || { echo "Simulation FAIL, see sim.log"; exit 1; }
